// File: verilog/ac_defs.svh
`default_nettype none

`ifndef AC_DEFS_SVH
`define AC_DEFS_SVH

// Width of one stream word and one buffer entry
`define AC_DATA_W 32

// Up-sampling elements, one output buffer each
`define AC_N_ELEM 2

// Words per output row, a multiple of AC_N_ELEM
`define AC_ROW_WORDS 8

// Rows per frame
`define AC_ROWS 4

// Entries per output buffer, a power of two
`define AC_FIFO_DEPTH 8

`endif

`default_nettype wire

// File: verilog/ac_pkg.sv
`include "ac_defs.svh"
`default_nettype none

package ac_pkg;

	typedef logic [`AC_DATA_W-1:0] word_t;

	// One bit per up-sampling element
	typedef logic [`AC_N_ELEM-1:0] elem_mask_t;

	// Status view of the control register, start bit at bit 0
	typedef struct packed {
		logic [29:0] rsvd;
		logic        up_end;
		logic        up_start;
	} crf_status_t;

	typedef union packed {
		logic [31:0] raw;
		crf_status_t status;
	} crf_word_t;

endpackage

`default_nettype wire

// File: verilog/frame_control.sv
`timescale 1ns/1ns
`default_nettype none

module frame_control (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              up_start,
	input  logic              up_end,
	input  logic              frame_done,
	output logic              processing,
	output logic              win,
	output logic              crf_wrt,
	output ac_pkg::crf_word_t crf_wdata
);
	import ac_pkg::*;

	logic      start_req;
	logic      stop_req;
	logic      wb_done;
	logic      wb_idle;
	crf_word_t wb_next;

	// Host has set start and the controller is idle
	assign start_req = up_start & ~up_end & ~processing;
	// Host has seen the end bit and cleared start
	assign stop_req  = ~up_start & up_end & processing;

	// Frame sent, start bit still set in the register file
	assign wb_done = processing & frame_done & up_start;
	// Start already cleared, keep raising end until it shows up
	assign wb_idle = processing & ~up_start & ~up_end;

	always_comb begin
		wb_next = '0;
		if (wb_done) begin
			wb_next.status.up_start = 1'b0;
			wb_next.status.up_end   = up_end;
		end else begin
			wb_next.status.up_end = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			processing <= 1'b0;
		end else if (start_req) begin
			processing <= 1'b1;
		end else if (stop_req) begin
			processing <= 1'b0;
		end
	end

	// Elements may write only while the window is open
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win <= 1'b0;
		end else if (start_req) begin
			win <= 1'b1;
		end else if (frame_done) begin
			win <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			crf_wrt   <= 1'b0;
			crf_wdata <= '0;
		end else begin
			crf_wrt <= wb_done | wb_idle;
			if (wb_done | wb_idle) begin
				crf_wdata <= wb_next;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/out_buffer.sv
`include "ac_defs.svh"
`timescale 1ns/1ns
`default_nettype none

module out_buffer (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          flush,
	input  logic          win,
	input  logic          wvalid,
	input  logic          rd,
	input  ac_pkg::word_t wdata,
	output logic          wready,
	output logic          empty,
	output ac_pkg::word_t rdata
);
	import ac_pkg::*;

	localparam int AW = $clog2(`AC_FIFO_DEPTH);

	word_t       mem [`AC_FIFO_DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        full;
	logic        wr_en;
	logic        rd_en;

	// Pointers carry one extra wrap bit to tell full from empty
	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
		(wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// Outside the window the element sees no acknowledge
	assign wready = win & ~full;
	assign wr_en  = wvalid & wready;
	assign rd_en  = rd & ~empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (flush) begin
			// Drop whatever is left at the end of a frame
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr[AW-1:0]] <= wdata;
		end
	end

	// Read data shows up the cycle after rd
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rdata <= mem[rd_ptr[AW-1:0]];
		end
	end

endmodule

`default_nettype wire

// File: verilog/column_arbiter.sv
`include "ac_defs.svh"
`timescale 1ns/1ns
`default_nettype none

module column_arbiter (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           win,
	input  ac_pkg::elem_mask_t             empty,
	input  ac_pkg::word_t [`AC_N_ELEM-1:0] rdata,
	input  logic                           out_ready,
	output ac_pkg::elem_mask_t             rd,
	output logic                           out_valid,
	output logic                           out_last,
	output logic                           frame_done,
	output ac_pkg::word_t                  out_data
);
	import ac_pkg::*;

	// Words of one row owned by each element
	localparam int SPAN  = `AC_ROW_WORDS / `AC_N_ELEM;
	localparam int COL_W = $clog2(`AC_ROW_WORDS);
	localparam int ROW_W = $clog2(`AC_ROWS + 1);

	localparam logic [COL_W-1:0] LAST_COL = COL_W'(`AC_ROW_WORDS - 1);
	localparam logic [ROW_W-1:0] ALL_ROWS = ROW_W'(`AC_ROWS);

	logic [COL_W-1:0] col_cnt;
	logic [ROW_W-1:0] row_cnt;
	logic             frame_read;
	logic             row_end;
	logic             advance;
	elem_mask_t       owner;
	elem_mask_t       sel_r;
	genvar            j;

	// Every word of the frame has left the buffers
	assign frame_read = (row_cnt == ALL_ROWS);
	assign row_end    = (col_cnt == LAST_COL);

	// Output register is empty or drains this cycle
	assign advance = ~out_valid | out_ready;

	// Element j owns columns j*SPAN up to (j+1)*SPAN-1 of each row
	generate
		for (j = 0; j < `AC_N_ELEM; j++) begin : g_span
			assign owner[j] = (int'(col_cnt) >= j * SPAN) &&
				(int'(col_cnt) < (j + 1) * SPAN);
		end
	endgenerate

	// At most one owner, so the read grant is one-hot
	assign rd = owner & ~empty & {`AC_N_ELEM{win & advance & ~frame_read}};

	// Position of the next word to read inside the frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (frame_done) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (|rd) begin
			if (row_end) begin
				col_cnt <= '0;
				row_cnt <= row_cnt + 1'b1;
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	// Output register, loaded together with the buffer read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
			sel_r     <= '0;
		end else if (advance) begin
			out_valid <= |rd;
			out_last  <= |rd & row_end;
			sel_r     <= rd;
		end
	end

	// Buffer read data is registered, so the grant from the read cycle
	// picks it; while stalled neither the grant nor the data move
	always_comb begin
		out_data = '0;
		for (int i = 0; i < `AC_N_ELEM; i++) begin
			if (sel_r[i]) begin
				out_data = rdata[i];
			end
		end
	end

	// Last word of the last row accepted downstream
	assign frame_done = out_valid & out_ready & out_last & frame_read;

endmodule

`default_nettype wire

// File: verilog/access_control.sv
`include "ac_defs.svh"
`timescale 1ns/1ns
`default_nettype none

module access_control (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           up_start,
	input  logic                           up_end,
	input  ac_pkg::elem_mask_t             elem_wvalid,
	input  ac_pkg::word_t [`AC_N_ELEM-1:0] elem_wdata,
	output ac_pkg::elem_mask_t             elem_wready,
	output logic                           out_valid,
	input  logic                           out_ready,
	output ac_pkg::word_t                  out_data,
	output logic                           out_last,
	output logic                           crf_wrt,
	output ac_pkg::crf_word_t              crf_wdata,
	output logic                           processing
);
	import ac_pkg::*;

	logic                       win;
	logic                       frame_done;
	elem_mask_t                 rd;
	elem_mask_t                 empty;
	word_t [`AC_N_ELEM-1:0]     buf_rdata;
	genvar                      j;

	frame_control u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.up_start   (up_start),
		.up_end     (up_end),
		.frame_done (frame_done),
		.processing (processing),
		.win        (win),
		.crf_wrt    (crf_wrt),
		.crf_wdata  (crf_wdata)
	);

	// One buffer per element, all emptied when the frame is done
	generate
		for (j = 0; j < `AC_N_ELEM; j++) begin : g_buf
			out_buffer u_buf (
				.clk    (clk),
				.rst_n  (rst_n),
				.flush  (frame_done),
				.win    (win),
				.wvalid (elem_wvalid[j]),
				.rd     (rd[j]),
				.wdata  (elem_wdata[j]),
				.wready (elem_wready[j]),
				.empty  (empty[j]),
				.rdata  (buf_rdata[j])
			);
		end
	endgenerate

	// Buffers share the single output stream through the arbiter
	column_arbiter u_arb (
		.clk        (clk),
		.rst_n      (rst_n),
		.win        (win),
		.empty      (empty),
		.rdata      (buf_rdata),
		.out_ready  (out_ready),
		.rd         (rd),
		.out_valid  (out_valid),
		.out_last   (out_last),
		.frame_done (frame_done),
		.out_data   (out_data)
	);

endmodule

`default_nettype wire

// File: test/access_control_sva.sv
`timescale 1ns/1ns
`default_nettype none

module access_control_sva (
	input logic          clk,
	input logic          rst_n,
	input logic          out_valid,
	input logic          out_ready,
	input ac_pkg::word_t out_data,
	input logic          out_last,
	input logic          crf_wrt,
	input logic          processing
);
	// Number of failed assertions
	int fail_cnt = 0;

	// A stalled word keeps its data and its row flag
	property p_stall_hold;
		@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last);
	endproperty

	// Write-backs only belong to a running frame
	property p_wrt_in_frame;
		@(posedge clk) disable iff (!rst_n)
		crf_wrt |-> processing;
	endproperty

	// First clocked update after reset release
	property p_idle_after_reset;
		@(posedge clk)
		$rose(rst_n) |=> !out_valid;
	endproperty

	a_stall_hold: assert property (p_stall_hold)
	else begin
		$error("output word changed while stalled");
		fail_cnt++;
	end

	a_wrt_in_frame: assert property (p_wrt_in_frame)
	else begin
		$error("register-file write-back while not processing");
		fail_cnt++;
	end

	a_idle_after_reset: assert property (p_idle_after_reset)
	else begin
		$error("out_valid high right after reset release");
		fail_cnt++;
	end

endmodule

bind access_control access_control_sva u_sva (
	.clk        (clk),
	.rst_n      (rst_n),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.out_data   (out_data),
	.out_last   (out_last),
	.crf_wrt    (crf_wrt),
	.processing (processing)
);

`default_nettype wire

// File: test/tb_access_control.sv
`include "ac_defs.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_access_control;
	import ac_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int SPAN         = `AC_ROW_WORDS / `AC_N_ELEM;
	localparam int PER_ELEM     = SPAN * `AC_ROWS;
	localparam int FRAME_WORDS  = `AC_ROW_WORDS * `AC_ROWS;
	// Words of a frame plus start-up and write-back cycles
	localparam int FRAME_CYCLES = FRAME_WORDS + 16;
	localparam int WATCHDOG_CYCLES = 10 + 2 * FRAME_CYCLES * 4 + 200;

	logic                   clk;
	logic                   rst_n;
	logic                   reg_start;
	logic                   reg_end;
	elem_mask_t             elem_wvalid;
	word_t [`AC_N_ELEM-1:0] elem_wdata;
	elem_mask_t             elem_wready;
	logic                   out_valid;
	logic                   out_ready;
	word_t                  out_data;
	logic                   out_last;
	logic                   crf_wrt;
	crf_word_t              crf_wdata;
	logic                   processing;

	int        n_checks;
	int        n_errors;
	word_t     src_words [`AC_N_ELEM][PER_ELEM];
	word_t     exp_q [$];
	crf_word_t wb_q [$];

	access_control u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.up_start    (reg_start),
		.up_end      (reg_end),
		.elem_wvalid (elem_wvalid),
		.elem_wdata  (elem_wdata),
		.elem_wready (elem_wready),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.out_data    (out_data),
		.out_last    (out_last),
		.crf_wrt     (crf_wrt),
		.crf_wdata   (crf_wdata),
		.processing  (processing)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the DUT stopped making progress",
			WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

	task automatic check_word(input string name, input word_t got, input word_t want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, want);
		end
	endtask

	task automatic check_crf(input string name, input crf_word_t got, input crf_word_t want);
		n_checks++;
		if (got.raw !== want.raw) begin
			n_errors++;
			$display("FAILED time=%0t %s got=%h expected=%h", $time, name, got.raw, want.raw);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		n_checks++;
		if (got !== want) begin
			n_errors++;
			$display("FAILED time=%0t %s got=%b expected=%b", $time, name, got, want);
		end
	endtask

	// One clock edge; the register file takes any write-back through the status view
	task automatic tick();
		@(posedge clk);
		if (crf_wrt) begin
			wb_q.push_back(crf_wdata);
			reg_start <= crf_wdata.status.up_start;
			reg_end   <= crf_wdata.status.up_end;
		end
	endtask

	task automatic apply_reset();
		rst_n <= 1'b0;
		repeat (10) tick();
		rst_n <= 1'b1;
		tick();
		check_bit("out_valid", out_valid, 1'b0);
		check_bit("out_last", out_last, 1'b0);
		check_bit("crf_wrt", crf_wrt, 1'b0);
		check_bit("processing", processing, 1'b0);
	endtask

	// Elements push words while the window is closed
	task automatic offer_closed_window();
		for (int c = 0; c < 6; c++) begin
			for (int j = 0; j < `AC_N_ELEM; j++) begin
				elem_wvalid[j] <= 1'b1;
				elem_wdata[j]  <= word_t'($urandom());
			end
			tick();
			for (int j = 0; j < `AC_N_ELEM; j++) begin
				check_bit($sformatf("elem_wready[%0d]", j), elem_wready[j], 1'b0);
			end
			check_bit("out_valid", out_valid, 1'b0);
		end
		elem_wvalid <= '0;
		tick();
	endtask

	task automatic prepare_frame();
		exp_q.delete();
		wb_q.delete();
		for (int j = 0; j < `AC_N_ELEM; j++) begin
			for (int k = 0; k < PER_ELEM; k++) begin
				src_words[j][k] = word_t'($urandom());
			end
		end
		// Each row takes SPAN words in turn from every element
		for (int r = 0; r < `AC_ROWS; r++) begin
			for (int col = 0; col < `AC_ROW_WORDS; col++) begin
				exp_q.push_back(src_words[col / SPAN][r * SPAN + col % SPAN]);
			end
		end
	endtask

	task automatic run_frame(input bit random_ready);
		int    wr_idx [`AC_N_ELEM];
		int    rcv;
		word_t want;
		prepare_frame();
		for (int j = 0; j < `AC_N_ELEM; j++) begin
			wr_idx[j] = 0;
		end
		rcv = 0;
		reg_start <= 1'b1;
		reg_end   <= 1'b0;
		tick();
		while (!processing) begin
			tick();
		end
		while (rcv < FRAME_WORDS) begin
			for (int j = 0; j < `AC_N_ELEM; j++) begin
				if (wr_idx[j] <= PER_ELEM && (!random_ready || $urandom % 4 != 0)) begin
					elem_wvalid[j] <= 1'b1;
					// One word past the frame stays behind until the flush
					if (wr_idx[j] < PER_ELEM) begin
						elem_wdata[j] <= src_words[j][wr_idx[j]];
					end else begin
						elem_wdata[j] <= word_t'($urandom());
					end
				end else begin
					elem_wvalid[j] <= 1'b0;
				end
			end
			out_ready <= random_ready ? ($urandom % 2 == 0) : 1'b1;
			tick();
			for (int j = 0; j < `AC_N_ELEM; j++) begin
				if (elem_wvalid[j] && elem_wready[j]) begin
					wr_idx[j]++;
				end
			end
			if (out_valid && out_ready) begin
				want = exp_q.pop_front();
				check_word("out_data", out_data, want);
				check_bit("out_last", out_last, (rcv % `AC_ROW_WORDS) == `AC_ROW_WORDS - 1);
				rcv++;
			end
		end
		elem_wvalid <= '0;
	endtask

	// Write-backs after the last word until the host's end bit stops processing
	task automatic finish_frame();
		crf_word_t want_wb;
		out_ready <= 1'b1;
		tick();
		while (processing) begin
			check_bit("out_valid", out_valid, 1'b0);
			tick();
		end
		check_bit("crf_wrt", crf_wrt, 1'b0);
		if (wb_q.size() < 2) begin
			n_errors++;
			$display("Only %0d register-file write-backs at frame end, at least 2 expected",
				wb_q.size());
		end else begin
			// Start cleared and end copied from the still-low end bit
			want_wb = '0;
			check_crf("crf_wdata", wb_q[0], want_wb);
			want_wb.status.up_end = 1'b1;
			for (int i = 1; i < wb_q.size(); i++) begin
				check_crf("crf_wdata", wb_q[i], want_wb);
			end
		end
		check_bit("reg_start", reg_start, 1'b0);
		check_bit("reg_end", reg_end, 1'b1);
	endtask

	initial begin
		void'($urandom(32'h596a_924d));
		n_checks = 0;
		n_errors = 0;
		rst_n       <= 1'b0;
		reg_start   <= 1'b0;
		reg_end     <= 1'b0;
		elem_wvalid <= '0;
		elem_wdata  <= '0;
		out_ready   <= 1'b0;
		apply_reset();
		offer_closed_window();
		run_frame(1'b0);
		finish_frame();
		offer_closed_window();
		run_frame(1'b1);
		finish_frame();
		// Full rate again from flushed buffers
		offer_closed_window();
		run_frame(1'b0);
		finish_frame();
		$display("checks %0d, errors %0d, assertion failures %0d",
			n_checks, n_errors, u_dut.u_sva.fail_cnt);
		if (n_errors == 0 && u_dut.u_sva.fail_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/ac_pkg.sv
verilog/frame_control.sv
verilog/out_buffer.sv
verilog/column_arbiter.sv
verilog/access_control.sv
test/access_control_sva.sv
test/tb_access_control.sv

// File: run.sh
#!/bin/sh
# Build and run the access controller simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns \
	--top-module tb_access_control \
	-f src.f \
	-o sim_access_control

out=$(./obj_dir/sim_access_control +verilator+error+limit+100)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'test passed'; then
	echo "simulation ok"
	exit 0
fi

echo "simulation reported failure"
exit 1
